// File: zoom_macros.svh
// sizes for the 2:1 downscaler; ZOOM_LINE_LEN must be even and ZOOM_HALF_LEN a power of two
`ifndef ZOOM_MACROS_SVH
`define ZOOM_MACROS_SVH

// pixel word and channel
`define ZOOM_PIXEL_W 32
`define ZOOM_CHAN_W 10

// 16 pixel lines keep simulation short
`define ZOOM_LINE_LEN 16
`define ZOOM_HALF_LEN (`ZOOM_LINE_LEN / 2)

// in-page address width is log2 of ZOOM_HALF_LEN
`define ZOOM_ADDR_W 3

// even and odd line of a pair
`define ZOOM_NUM_BUFS 2

`endif

// File: zoom_pkg.sv
// pixel types for the downscaler; bits 1:0 of a pixel carry no data and stay zero
`default_nettype none

`include "zoom_macros.svh"

package zoom_pkg;

  typedef logic [`ZOOM_CHAN_W-1:0] chan_t;

  typedef struct packed {
    chan_t      ch_r;  // bits 31:22
    chan_t      ch_g;  // bits 21:12
    chan_t      ch_b;  // bits 11:2
    logic [1:0] pad;
  } pixel_t;

  typedef struct packed {
    logic                    page;
    logic [`ZOOM_ADDR_W-1:0] idx;
  } buf_addr_t;

  // each half rounds down on its own, so the sum never overflows
  function automatic pixel_t pair_avg(pixel_t a, pixel_t b);
    pixel_t r;
    r.ch_r = (a.ch_r >> 1) + (b.ch_r >> 1);
    r.ch_g = (a.ch_g >> 1) + (b.ch_g >> 1);
    r.ch_b = (a.ch_b >> 1) + (b.ch_b >> 1);
    r.pad  = 2'b00;
    return r;
  endfunction

endpackage

`default_nettype wire

// File: h_decimator.sv
// expects de_in bursts of exactly ZOOM_LINE_LEN pixels; a shorter burst leaves a partial line
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module h_decimator (
  input  wire                        clk,
  input  wire                        rstn,
  input  wire                        frame_restart,
  input  wire                        de_in,
  input  wire zoom_pkg::pixel_t      video_data_in,
  output logic [`ZOOM_NUM_BUFS-1:0]  wr_en,
  output zoom_pkg::buf_addr_t        wr_addr,
  output zoom_pkg::pixel_t           wr_data,
  output logic                       pair_done,
  output logic                       rd_page
);

  logic                    de_d;      // for the end of line
  logic                    phase;     // 1 on the second pixel of a pair
  logic [`ZOOM_ADDR_W-1:0] idx;
  logic                    line_odd;  // selects the buffer
  logic                    page;
  zoom_pkg::pixel_t        first_pix;

  // control state that frame restart also clears
  always_ff @(posedge clk) begin
    if (!rstn || frame_restart) begin
      de_d      <= 1'b0;
      phase     <= 1'b0;
      idx       <= '0;
      line_odd  <= 1'b0;
      page      <= 1'b0;
      wr_en     <= '0;
      pair_done <= 1'b0;
      rd_page   <= 1'b0;
    end else begin
      de_d      <= de_in;
      wr_en     <= '0;
      pair_done <= 1'b0;
      if (de_in) begin
        phase <= ~phase;
        if (phase) begin
          wr_en[line_odd] <= 1'b1;
          idx             <= idx + 1'b1;
        end
      end else if (de_d) begin
        // line just ended
        phase    <= 1'b0;
        idx      <= '0;
        line_odd <= ~line_odd;
        if (line_odd) begin
          page      <= ~page;  // next pair writes the other page
          rd_page   <= page;
          pair_done <= 1'b1;
        end
      end
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (de_in && !phase) begin
      first_pix <= video_data_in;
    end
    if (de_in && phase) begin
      wr_data      <= zoom_pkg::pair_avg(first_pix, video_data_in);
      wr_addr.page <= page;
      wr_addr.idx  <= idx;
    end
  end

endmodule

`default_nettype wire

// File: line_buffer.sv
// two pages of ZOOM_HALF_LEN pixels; read data is undefined until a location has been written
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module line_buffer (
  input  wire                       clk,
  input  wire                       wr_en,
  input  wire zoom_pkg::buf_addr_t  wr_addr,
  input  wire zoom_pkg::pixel_t     wr_data,
  input  wire zoom_pkg::buf_addr_t  rd_addr,
  output zoom_pkg::pixel_t          rd_data
);

  localparam int DEPTH = 2 * `ZOOM_HALF_LEN;

  // page bit is the address msb
  zoom_pkg::pixel_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[{wr_addr.page, wr_addr.idx}] <= wr_data;
    end
  end

  // registered read with one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[{rd_addr.page, rd_addr.idx}];
  end

endmodule

`default_nettype wire

// File: v_averager.sv
// one readout per pair_done; the next pair_done must come after ZOOM_HALF_LEN + 2 idle cycles
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module v_averager (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    frame_restart,
  input  wire                    pair_done,
  input  wire                    rd_page,
  input  wire zoom_pkg::pixel_t  rd_data0,
  input  wire zoom_pkg::pixel_t  rd_data1,
  output zoom_pkg::buf_addr_t    rd_addr,
  output logic                   de_out,
  output zoom_pkg::pixel_t       video_data_out
);

  localparam logic [`ZOOM_ADDR_W-1:0] LAST_IDX = `ZOOM_ADDR_W'(`ZOOM_HALF_LEN - 1);

  logic rd_act;  // rd_addr is live this cycle
  logic rd_vld;  // rd_data0/1 are valid this cycle

  // read address sweep
  always_ff @(posedge clk) begin
    if (!rstn || frame_restart) begin
      rd_act  <= 1'b0;
      rd_addr <= '0;
    end else if (pair_done) begin
      rd_act       <= 1'b1;
      rd_addr.page <= rd_page;
      rd_addr.idx  <= '0;
    end else if (rd_act) begin
      if (rd_addr.idx == LAST_IDX) begin
        rd_act <= 1'b0;  // address stays on the last pixel
      end else begin
        rd_addr.idx <= rd_addr.idx + 1'b1;
      end
    end
  end

  // latency match and output register
  always_ff @(posedge clk) begin
    if (!rstn || frame_restart) begin
      rd_vld         <= 1'b0;
      de_out         <= 1'b0;
      video_data_out <= '0;
    end else begin
      rd_vld <= rd_act;
      de_out <= rd_vld;
      if (rd_vld) begin
        video_data_out <= zoom_pkg::pair_avg(rd_data0, rd_data1);
      end else begin
        video_data_out <= '0;  // blank between bursts
      end
    end
  end

endmodule

`default_nettype wire

// File: video_zoom.sv
// no back-pressure; de_in gaps must be at least ZOOM_HALF_LEN + 4 cycles and a vs_in fall restarts the frame
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module video_zoom (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    vs_in,
  input  wire                    de_in,
  input  wire zoom_pkg::pixel_t  video_data_in,
  output logic                   de_out,
  output zoom_pkg::pixel_t       video_data_out
);

  logic                      vs_d0;
  logic                      vs_d1;
  logic                      frame_restart;
  logic [`ZOOM_NUM_BUFS-1:0] wr_en;
  zoom_pkg::buf_addr_t       wr_addr;
  zoom_pkg::pixel_t          wr_data;
  zoom_pkg::buf_addr_t       rd_addr;
  zoom_pkg::pixel_t          rd_data [`ZOOM_NUM_BUFS];
  logic                      pair_done;
  logic                      rd_page;

  // vs_in falling edge
  always_ff @(posedge clk) begin
    if (!rstn) begin
      vs_d0 <= 1'b0;
      vs_d1 <= 1'b0;
    end else begin
      vs_d0 <= vs_in;
      vs_d1 <= vs_d0;
    end
  end

  assign frame_restart = vs_d1 && !vs_d0;

  h_decimator u_hdec (
    .clk           (clk),
    .rstn          (rstn),
    .frame_restart (frame_restart),
    .de_in         (de_in),
    .video_data_in (video_data_in),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .pair_done     (pair_done),
    .rd_page       (rd_page)
  );

  // buffer 0 holds even lines and buffer 1 odd lines
  for (genvar i = 0; i < `ZOOM_NUM_BUFS; i++) begin : g_buf
    line_buffer u_buf (
      .clk     (clk),
      .wr_en   (wr_en[i]),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data[i])
    );
  end

  v_averager u_vavg (
    .clk            (clk),
    .rstn           (rstn),
    .frame_restart  (frame_restart),
    .pair_done      (pair_done),
    .rd_page        (rd_page),
    .rd_data0       (rd_data[0]),
    .rd_data1       (rd_data[1]),
    .rd_addr        (rd_addr),
    .de_out         (de_out),
    .video_data_out (video_data_out)
  );

endmodule

`default_nettype wire

// File: zoom_checker.sv
// reference model; expects whole input lines and no readout in flight when vs_in falls
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module zoom_checker (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire                      vs_in,
  input  wire                      de_in,
  input  wire [`ZOOM_PIXEL_W-1:0]  video_data_in,
  input  wire                      de_out,
  input  wire [`ZOOM_PIXEL_W-1:0]  video_data_out,
  input  wire [31:0]               exp_bursts,
  input  wire                      end_check,
  output logic                     report_done,
  output logic [31:0]              error_count,
  output logic [31:0]              pending
);

  logic [`ZOOM_PIXEL_W-1:0] exp_q [$];
  logic [`ZOOM_PIXEL_W-1:0] h_cur  [`ZOOM_HALF_LEN];  // halved line being received
  logic [`ZOOM_PIXEL_W-1:0] h_even [`ZOOM_HALF_LEN];  // halved even line of the pair
  logic [`ZOOM_PIXEL_W-1:0] first_pix;
  logic [`ZOOM_PIXEL_W-1:0] exp_pix;
  int   in_idx     = 0;
  int   run_len    = 0;
  int   bursts     = 0;
  int   compared   = 0;
  int   mismatches = 0;
  int   other_errs = 0;
  int   queue_len  = 0;
  logic line_odd   = 1'b0;
  logic de_in_d    = 1'b0;
  logic de_out_d   = 1'b0;
  logic vs_d       = 1'b0;
  logic done_flag  = 1'b0;

  assign report_done = done_flag;
  assign error_count = 32'(mismatches + other_errs);
  assign pending     = 32'(queue_len);

  // each channel gets half of a rounded down plus half of b rounded down
  function automatic logic [31:0] avg_pixels(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    r        = '0;
    r[31:22] = {1'b0, a[31:23]} + {1'b0, b[31:23]};
    r[21:12] = {1'b0, a[21:13]} + {1'b0, b[21:13]};
    r[11:2]  = {1'b0, a[11:3]} + {1'b0, b[11:3]};
    return r;
  endfunction

  // sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk) begin
    int k;
    if (rstn) begin
      if (vs_d && !vs_in) begin
        line_odd = 1'b0;  // a waiting even line is dropped
        in_idx   = 0;
      end
      if (de_in) begin
        if (in_idx[0]) h_cur[in_idx / 2] = avg_pixels(first_pix, video_data_in);
        else first_pix = video_data_in;
        in_idx++;
      end else if (de_in_d) begin
        if (line_odd) begin
          for (k = 0; k < `ZOOM_HALF_LEN; k++) exp_q.push_back(avg_pixels(h_even[k], h_cur[k]));
        end else begin
          for (k = 0; k < `ZOOM_HALF_LEN; k++) h_even[k] = h_cur[k];
        end
        line_odd = ~line_odd;
        in_idx   = 0;
      end

      if (de_out === 1'b1) begin
        run_len++;
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("ERROR at %0t: de_out is high but no output pixel was expected", $time);
        end else begin
          exp_pix = exp_q.pop_front();
          compared++;
          if (video_data_out !== exp_pix) begin
            mismatches++;
            $display("MISMATCH at %0t: video_data_out got %h expected %h",
                     $time, video_data_out, exp_pix);
          end
        end
      end else begin
        if (de_out !== 1'b0) begin
          other_errs++;
          $display("ERROR at %0t: de_out is unknown", $time);
        end
        if (video_data_out !== '0) begin
          mismatches++;
          $display("MISMATCH at %0t: video_data_out got %h expected %h",
                   $time, video_data_out, 32'h0);
        end
        if (de_out_d === 1'b1) begin
          bursts++;
          if (run_len != `ZOOM_HALF_LEN) begin
            other_errs++;
            $display("ERROR at %0t: de_out burst lasted %0d cycles instead of %0d",
                     $time, run_len, `ZOOM_HALF_LEN);
          end
        end
        run_len = 0;
      end
    end
    vs_d      = vs_in;
    de_in_d   = de_in;
    de_out_d  = de_out;
    queue_len = exp_q.size();

    if (end_check && !done_flag) begin
      if (exp_q.size() != 0) begin
        other_errs++;
        $display("ERROR: %0d expected pixels never came out", exp_q.size());
      end
      if (bursts != exp_bursts) begin
        other_errs++;
        $display("ERROR: saw %0d output bursts but expected %0d", bursts, exp_bursts);
      end
      $display("checker: %0d pixels compared, %0d bursts, %0d mismatches, %0d other errors",
               compared, bursts, mismatches, other_errs);
      done_flag = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tb_video_zoom.sv
// drives whole lines only; table blanking must stay at or above ZOOM_HALF_LEN + 4 cycles
`timescale 1ns/1ns
`default_nettype none

`include "zoom_macros.svh"

module tb_video_zoom;

  localparam int NUM_LINES    = 11;
  localparam int RESET_CYCLES = 16;
  localparam int VS_CYCLES    = 6;  // vs_in pulse plus settle before the line

  localparam logic [1:0] MODE_FIXED = 2'd0;
  localparam logic [1:0] MODE_RAMP  = 2'd1;
  localparam logic [1:0] MODE_RAND  = 2'd2;

  logic                     clk;
  logic                     rstn;
  logic                     vs_in;
  logic                     de_in;
  logic [`ZOOM_PIXEL_W-1:0] video_data_in;
  logic                     de_out;
  logic [`ZOOM_PIXEL_W-1:0] video_data_out;

  // line descriptors
  logic [1:0]  tbl_mode  [NUM_LINES];
  logic [31:0] tbl_value [NUM_LINES];
  logic [31:0] tbl_step  [NUM_LINES];
  int          tbl_blank [NUM_LINES];
  logic        tbl_vs    [NUM_LINES];
  logic        tbl_burst [NUM_LINES];  // line closes a pair

  integer      seed;
  int          cycles      = 0;
  int          cycle_limit = 0;
  logic [31:0] exp_bursts;
  logic        end_check;
  logic        report_done;
  logic [31:0] error_count;
  logic [31:0] pending;

  video_zoom uut (
    .clk            (clk),
    .rstn           (rstn),
    .vs_in          (vs_in),
    .de_in          (de_in),
    .video_data_in  (video_data_in),
    .de_out         (de_out),
    .video_data_out (video_data_out)
  );

  zoom_checker u_checker (
    .clk            (clk),
    .rstn           (rstn),
    .vs_in          (vs_in),
    .de_in          (de_in),
    .video_data_in  (video_data_in),
    .de_out         (de_out),
    .video_data_out (video_data_out),
    .exp_bursts     (exp_bursts),
    .end_check      (end_check),
    .report_done    (report_done),
    .error_count    (error_count),
    .pending        (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic set_line(input int n, input logic [1:0] mode, input logic [31:0] value,
                          input logic [31:0] step, input int blank, input logic vs,
                          input logic burst);
    tbl_mode[n]  = mode;
    tbl_value[n] = value;
    tbl_step[n]  = step;
    tbl_blank[n] = blank;
    tbl_vs[n]    = vs;
    tbl_burst[n] = burst;
  endtask

  task automatic load_table();
    // pad bits are set in the input and must come out as zero
    set_line(0, MODE_FIXED, {10'd3, 10'd1023, 10'd512, 2'b11}, 32'h0, 14, 1'b0, 1'b0);
    set_line(1, MODE_FIXED, {10'd3, 10'd1023, 10'd512, 2'b11}, 32'h0, 12, 1'b0, 1'b1);
    set_line(2, MODE_RAMP, 32'h0040_1004, 32'h0040_1004, 16, 1'b0, 1'b0);
    set_line(3, MODE_RAMP, 32'h1000_8000, 32'h00c0_3014, 13, 1'b0, 1'b1);
    set_line(4, MODE_RAND, 32'h0, 32'h0, 12, 1'b0, 1'b0);
    set_line(5, MODE_RAND, 32'h0, 32'h0, 15, 1'b0, 1'b1);
    set_line(6, MODE_RAND, 32'h0, 32'h0, 12, 1'b0, 1'b0);  // lone even line that vs_in drops
    set_line(7, MODE_FIXED, {10'd700, 10'd5, 10'd1, 2'b01}, 32'h0, 12, 1'b1, 1'b0);
    set_line(8, MODE_RAMP, 32'h2008_0400, 32'h0100_2008, 14, 1'b0, 1'b1);
    set_line(9, MODE_RAND, 32'h0, 32'h0, 12, 1'b0, 1'b0);
    set_line(10, MODE_FIXED, {10'd1023, 10'd0, 10'd341, 2'b10}, 32'h0, 20, 1'b0, 1'b1);
  endtask

  task automatic drive_line(input int n);
    int          i;
    logic [31:0] pix;
    if (tbl_vs[n]) begin
      vs_in <= 1'b1;
      repeat (2) @(posedge clk);
      vs_in <= 1'b0;
      repeat (VS_CYCLES - 2) @(posedge clk);
    end
    for (i = 0; i < `ZOOM_LINE_LEN; i++) begin
      case (tbl_mode[n])
        MODE_RAMP: pix = tbl_value[n] + i * tbl_step[n];
        MODE_RAND: pix = $random(seed);
        default:   pix = tbl_value[n];
      endcase
      de_in         <= 1'b1;
      video_data_in <= pix;
      @(posedge clk);
    end
    de_in         <= 1'b0;
    video_data_in <= '0;
    repeat (tbl_blank[n]) @(posedge clk);
  endtask

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int n;
    int total;
    rstn          = 1'b0;
    vs_in         = 1'b0;
    de_in         = 1'b0;
    video_data_in = '0;
    end_check     = 1'b0;
    seed          = 32'he381;
    exp_bursts    = '0;
    load_table();
    total = RESET_CYCLES + 200;
    for (n = 0; n < NUM_LINES; n++) begin
      total += `ZOOM_LINE_LEN + tbl_blank[n];
      if (tbl_vs[n]) total += VS_CYCLES;
      if (tbl_burst[n]) exp_bursts = exp_bursts + 1;
    end
    cycle_limit = total;

    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    repeat (2) @(posedge clk);
    for (n = 0; n < NUM_LINES; n++) begin
      drive_line(n);
    end

    // drain until every expected pixel has come out
    @(negedge clk);
    while (pending != 0 || de_out !== 1'b0) @(negedge clk);
    @(posedge clk);
    end_check <= 1'b1;
    wait (report_done === 1'b1);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
zoom_pkg.sv
h_decimator.sv
line_buffer.sv
v_averager.sv
video_zoom.sv
zoom_checker.sv
tb_video_zoom.sv

// File: Bender.yml
package:
  name: video_zoom

sources:
  - include_dirs:
      - .
    files:
      - zoom_pkg.sv
      - h_decimator.sv
      - line_buffer.sv
      - v_averager.sv
      - video_zoom.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - zoom_checker.sv
      - tb_video_zoom.sv
